//--- list.f
logic/fir_types_pkg.sv
logic/settings_pkg.sv
logic/axis_if.sv
logic/fir_settings.sv
logic/fir_tap_line.sv
logic/fir_sum_stage.sv
logic/fir_output_stage.sv
logic/fir_block.sv
tests/fir_block_tb.sv

//--- logic/axis_if.sv
`timescale 1ns/1ps

interface axis_if;
  import fir_types_pkg::*;

  sample_t tdata;
  logic    tlast;
  logic    tvalid;
  logic    tready;

  // Upstream side of a link
  modport src (
    output tdata,
    output tlast,
    output tvalid,
    input  tready
  );

  // Downstream side of a link
  modport snk (
    input  tdata,
    input  tlast,
    input  tvalid,
    output tready
  );

endinterface

//--- logic/fir_block.sv
`timescale 1ns/1ps

module fir_block #(
  parameter int NUM_TAPS = 8
) (
  input  logic                    i_ce_clk,
  input  logic                    i_reset,
  // Settings bus
  input  logic                    i_set_stb,
  input  settings_pkg::set_addr_t i_set_addr,
  input  settings_pkg::set_data_t i_set_data,
  output settings_pkg::rb_data_t  o_rb_data,
  // Sample input
  input  fir_types_pkg::sample_t  i_tdata,
  input  logic                    i_tlast,
  input  logic                    i_tvalid,
  output logic                    o_tready_in,
  // Filtered output
  output fir_types_pkg::sample_t  o_tdata,
  output logic                    o_tlast,
  output logic                    o_tvalid,
  input  logic                    i_tready_out
);
  import fir_types_pkg::*;

  coef_t coefs    [0:NUM_TAPS-1];
  prod_t products [0:NUM_TAPS-1];
  acc_t  sum;

  axis_if s1 ();
  axis_if s2 ();

  ////////////////////////////////////////
  // Coefficient control
  ////////////////////////////////////////

  fir_settings #(
    .NUM_TAPS(NUM_TAPS)
  ) u_settings (
    .i_ce_clk  (i_ce_clk),
    .i_reset   (i_reset),
    .i_set_stb (i_set_stb),
    .i_set_addr(i_set_addr),
    .i_set_data(i_set_data),
    .o_rb_data (o_rb_data),
    .o_coefs   (coefs)
  );

  ////////////////////////////////////////
  // Filter pipeline
  ////////////////////////////////////////

  fir_tap_line #(
    .NUM_TAPS(NUM_TAPS)
  ) u_tap_line (
    .i_ce_clk  (i_ce_clk),
    .i_reset   (i_reset),
    .i_tdata   (i_tdata),
    .i_tlast   (i_tlast),
    .i_tvalid  (i_tvalid),
    .o_tready  (o_tready_in),
    .i_coefs   (coefs),
    .o_products(products),
    .o_stream  (s1.src)
  );

  fir_sum_stage #(
    .NUM_TAPS(NUM_TAPS)
  ) u_sum_stage (
    .i_ce_clk  (i_ce_clk),
    .i_reset   (i_reset),
    .i_products(products),
    .i_stream  (s1.snk),
    .o_stream  (s2.src),
    .o_sum     (sum)
  );

  fir_output_stage u_output_stage (
    .i_ce_clk(i_ce_clk),
    .i_reset (i_reset),
    .i_stream(s2.snk),
    .i_sum   (sum),
    .o_tdata (o_tdata),
    .o_tlast (o_tlast),
    .o_tvalid(o_tvalid),
    .i_tready(i_tready_out)
  );

endmodule

//--- logic/fir_output_stage.sv
`timescale 1ns/1ps

module fir_output_stage (
  input  logic                   i_ce_clk,
  input  logic                   i_reset,
  axis_if.snk                    i_stream,
  input  fir_types_pkg::acc_t    i_sum,
  output fir_types_pkg::sample_t o_tdata,
  output logic                   o_tlast,
  output logic                   o_tvalid,
  input  logic                   i_tready
);
  import fir_types_pkg::*;

  localparam acc_t HALF_LSB = acc_t'(1) <<< (COEF_FRAC - 1);

  acc_t    rounded;
  acc_t    scaled;
  sample_t clipped;
  logic    advance;

  ////////////////////////////////////////
  // Round half up, then clip
  ////////////////////////////////////////

  always_comb begin
    rounded = i_sum + HALF_LSB;
    scaled  = rounded >>> COEF_FRAC;
    if (scaled > acc_t'(SAMPLE_MAX)) begin
      clipped = SAMPLE_MAX;
    end else if (scaled < acc_t'(SAMPLE_MIN)) begin
      clipped = SAMPLE_MIN;
    end else begin
      clipped = sample_t'(scaled);
    end
  end

  // Empty slot or beat taken by the sink
  assign advance         = !o_tvalid || i_tready;
  assign i_stream.tready = advance;

  always_ff @(posedge i_ce_clk) begin
    if (i_reset) begin
      o_tvalid <= 1'b0;
      o_tlast  <= 1'b0;
    end else if (advance) begin
      o_tvalid <= i_stream.tvalid;
      o_tlast  <= i_stream.tlast;
    end
  end

  always_ff @(posedge i_ce_clk) begin
    if (advance && i_stream.tvalid) begin
      o_tdata <= clipped;
    end
  end

  // A stalled beat must not change under the sink
  a_hold_stable : assert property (@(posedge i_ce_clk) disable iff (i_reset)
    (o_tvalid && !i_tready) |=> (o_tvalid && $stable(o_tdata) && $stable(o_tlast)));

endmodule

//--- logic/fir_settings.sv
`timescale 1ns/1ps

module fir_settings #(
  parameter int NUM_TAPS = 8
) (
  input  logic                    i_ce_clk,
  input  logic                    i_reset,
  input  logic                    i_set_stb,
  input  settings_pkg::set_addr_t i_set_addr,
  input  settings_pkg::set_data_t i_set_data,
  output settings_pkg::rb_data_t  o_rb_data,
  output fir_types_pkg::coef_t    o_coefs [0:NUM_TAPS-1]
);
  import fir_types_pkg::*;
  import settings_pkg::*;

  localparam int IDX_W = $clog2(NUM_TAPS);

  coef_t            shadow [0:NUM_TAPS-1];
  coef_t            active [0:NUM_TAPS-1];
  logic [IDX_W-1:0] wr_idx;
  logic             complete;
  logic [2:0]       rb_sel;

  ////////////////////////////////////////
  // Register writes
  ////////////////////////////////////////

  always_ff @(posedge i_ce_clk) begin
    if (i_reset) begin
      for (int k = 0; k < NUM_TAPS; k++) begin
        shadow[k] <= '0;
        active[k] <= '0;
      end
      wr_idx   <= '0;
      complete <= 1'b0;
      rb_sel   <= '0;
    end else if (i_set_stb) begin
      case (i_set_addr)
        SR_RELOAD: begin
          shadow[wr_idx] <= coef_t'(i_set_data[15:0]);
          // Index wraps so a long reload overwrites from tap 0
          if (wr_idx == IDX_W'(NUM_TAPS - 1)) begin
            wr_idx <= '0;
          end else begin
            wr_idx <= wr_idx + 1'b1;
          end
        end
        SR_RELOAD_LAST: begin
          shadow[wr_idx] <= coef_t'(i_set_data[15:0]);
          wr_idx         <= '0;
          complete       <= 1'b1;
        end
        SR_CONFIG: begin
          // Partial reloads never reach the datapath
          if (complete) begin
            for (int k = 0; k < NUM_TAPS; k++) begin
              active[k] <= shadow[k];
            end
            complete <= 1'b0;
          end
        end
        SR_READBACK: begin
          rb_sel <= i_set_data[2:0];
        end
        default: begin
        end
      endcase
    end
  end

  assign o_coefs = active;

  // Readback mux
  always_comb begin
    case (rb_sel)
      RB_NUM_TAPS:      o_rb_data = rb_data_t'(NUM_TAPS);
      RB_RELOAD_STATUS: o_rb_data = rb_data_t'({complete, 8'(wr_idx)});
      default:          o_rb_data = RB_INVALID;
    endcase
  end

  a_idx_range : assert property (@(posedge i_ce_clk) disable iff (i_reset)
    int'(wr_idx) < NUM_TAPS);

endmodule

//--- logic/fir_sum_stage.sv
`timescale 1ns/1ps

module fir_sum_stage #(
  parameter int NUM_TAPS = 8
) (
  input  logic                 i_ce_clk,
  input  logic                 i_reset,
  input  fir_types_pkg::prod_t i_products [0:NUM_TAPS-1],
  axis_if.snk                  i_stream,
  axis_if.src                  o_stream,
  output fir_types_pkg::acc_t  o_sum
);
  import fir_types_pkg::*;

  acc_t total;
  logic valid_q;
  logic last_q;

  ////////////////////////////////////////
  // Adder tree
  ////////////////////////////////////////

  always_comb begin
    total = '0;
    for (int k = 0; k < NUM_TAPS; k++) begin
      total = total + acc_t'(i_products[k]);
    end
  end

  // Whole pipeline moves in lock step
  assign i_stream.tready = o_stream.tready;

  always_ff @(posedge i_ce_clk) begin
    if (o_stream.tready && i_stream.tvalid) begin
      o_sum <= total;
    end
  end

  always_ff @(posedge i_ce_clk) begin
    if (i_reset) begin
      valid_q <= 1'b0;
      last_q  <= 1'b0;
    end else if (o_stream.tready) begin
      valid_q <= i_stream.tvalid;
      last_q  <= i_stream.tlast;
    end
  end

  // Sum travels on o_sum
  assign o_stream.tdata  = '0;
  assign o_stream.tvalid = valid_q;
  assign o_stream.tlast  = last_q;

endmodule

//--- logic/fir_tap_line.sv
`timescale 1ns/1ps

module fir_tap_line #(
  parameter int NUM_TAPS = 8
) (
  input  logic                   i_ce_clk,
  input  logic                   i_reset,
  input  fir_types_pkg::sample_t i_tdata,
  input  logic                   i_tlast,
  input  logic                   i_tvalid,
  output logic                   o_tready,
  input  fir_types_pkg::coef_t   i_coefs [0:NUM_TAPS-1],
  output fir_types_pkg::prod_t   o_products [0:NUM_TAPS-1],
  axis_if.src                    o_stream
);
  import fir_types_pkg::*;

  // Past samples, newest first
  sample_t dline [0:NUM_TAPS-2];
  // Tap k sees the sample k beats back
  sample_t taps  [0:NUM_TAPS-1];
  logic    accept;
  logic    valid_q;
  logic    last_q;

  assign o_tready = o_stream.tready;
  assign accept   = i_tvalid && o_stream.tready;

  always_comb begin
    taps[0] = i_tdata;
    for (int k = 1; k < NUM_TAPS; k++) begin
      taps[k] = dline[k-1];
    end
  end

  always_ff @(posedge i_ce_clk) begin
    if (i_reset) begin
      for (int k = 0; k < NUM_TAPS - 1; k++) begin
        dline[k] <= '0;
      end
    end else if (accept) begin
      for (int k = 0; k < NUM_TAPS - 1; k++) begin
        dline[k] <= taps[k];
      end
    end
  end

  // Products use the coefficients live at the accept edge
  always_ff @(posedge i_ce_clk) begin
    if (accept) begin
      for (int k = 0; k < NUM_TAPS; k++) begin
        o_products[k] <= prod_t'(taps[k]) * prod_t'(i_coefs[k]);
      end
    end
  end

  always_ff @(posedge i_ce_clk) begin
    if (i_reset) begin
      valid_q <= 1'b0;
      last_q  <= 1'b0;
    end else if (o_stream.tready) begin
      valid_q <= i_tvalid;
      last_q  <= i_tlast;
    end
  end

  // Payload rides on o_products
  assign o_stream.tdata  = '0;
  assign o_stream.tvalid = valid_q;
  assign o_stream.tlast  = last_q;

endmodule

//--- logic/fir_types_pkg.sv
package fir_types_pkg;

  ////////////////////////////////////////
  // Datapath widths
  ////////////////////////////////////////

  // Real input and output samples
  typedef logic signed [15:0] sample_t;

  // Q1.15 coefficient
  typedef logic signed [15:0] coef_t;

  // Full precision tap product
  typedef logic signed [31:0] prod_t;

  // Sum of all taps, 8 guard bits cover 64 taps at full scale
  typedef logic signed [39:0] acc_t;

  ////////////////////////////////////////
  // Fixed point constants
  ////////////////////////////////////////

  // Fraction bits dropped by the output stage
  localparam int COEF_FRAC = 15;

  // Output clip limits
  localparam sample_t SAMPLE_MAX = 16'sh7FFF;
  localparam sample_t SAMPLE_MIN = 16'sh8000;

endpackage

//--- logic/settings_pkg.sv
package settings_pkg;

  // Bus word types
  typedef logic [7:0]  set_addr_t;
  typedef logic [31:0] set_data_t;
  typedef logic [63:0] rb_data_t;

  ////////////////////////////////////////
  // Register map
  ////////////////////////////////////////

  // Copy shadow bank to active bank
  localparam set_addr_t SR_CONFIG      = 8'd129;
  // Next coefficient in data[15:0]
  localparam set_addr_t SR_RELOAD      = 8'd130;
  // Final coefficient, marks shadow bank complete
  localparam set_addr_t SR_RELOAD_LAST = 8'd131;
  // Readback selector in data[2:0]
  localparam set_addr_t SR_READBACK    = 8'd255;

  // Readback selector codes
  typedef enum logic [2:0] {
    RB_NUM_TAPS      = 3'd0,
    RB_RELOAD_STATUS = 3'd1
  } rb_sel_t;

  // Returned for unknown selectors
  localparam rb_data_t RB_INVALID = 64'h0BADC0DE0BADC0DE;

endpackage

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the FIR block testbench with Verilator, runs it and checks the log
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -j 0 \
  --top-module fir_block_tb -Mdir "$OBJ" -f list.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ/Vfir_block_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "SIMULATION PASSED" "$LOG"; then
  exit 0
else
  exit 1
fi

//--- tests/fir_block_tb.sv
`timescale 1ns/1ps

module fir_block_tb;
  import fir_types_pkg::*;
  import settings_pkg::*;

  localparam int NUM_TAPS   = 8;
  localparam int WAIT_LIMIT = 2000;

  logic      clk;
  logic      reset;
  logic      set_stb;
  set_addr_t set_addr;
  set_data_t set_data;
  rb_data_t  rb_data;
  sample_t   in_tdata;
  logic      in_tlast;
  logic      in_tvalid;
  logic      in_tready;
  sample_t   out_tdata;
  logic      out_tlast;
  logic      out_tvalid;
  logic      out_tready;

  // Reference model state
  coef_t   coef_model [0:NUM_TAPS-1];
  coef_t   load_vals  [0:NUM_TAPS-1];
  sample_t hist       [0:NUM_TAPS-1];
  sample_t exp_data   [$];
  logic    exp_last   [$];
  sample_t stim_data  [$];
  logic    stim_last  [$];
  sample_t last_out;

  int   errors;
  int   tests_passed;
  int   tests_failed;
  logic timed_out;

  fir_block #(
    .NUM_TAPS(NUM_TAPS)
  ) DUT (
    .i_ce_clk    (clk),
    .i_reset     (reset),
    .i_set_stb   (set_stb),
    .i_set_addr  (set_addr),
    .i_set_data  (set_data),
    .o_rb_data   (rb_data),
    .i_tdata     (in_tdata),
    .i_tlast     (in_tlast),
    .i_tvalid    (in_tvalid),
    .o_tready_in (in_tready),
    .o_tdata     (out_tdata),
    .o_tlast     (out_tlast),
    .o_tvalid    (out_tvalid),
    .i_tready_out(out_tready)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic compare_sample(input string name, input sample_t expected,
                                input sample_t actual);
    if (actual !== expected) begin
      errors++;
      $display("FAILED at %0d ns: %s expected %0d, got %0d", $time, name, expected, actual);
    end
  endtask

  task automatic compare_last(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      errors++;
      $display("FAILED at %0d ns: %s expected %b, got %b", $time, name, expected, actual);
    end
  endtask

  // Handshake flags
  task automatic compare_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      errors++;
      $display("FAILED at %0d ns: %s expected %b, got %b", $time, name, expected, actual);
    end
  endtask

  task automatic compare_rb(input string name, input rb_data_t expected,
                            input rb_data_t actual);
    if (actual !== expected) begin
      errors++;
      $display("FAILED at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // Round half up, drop fraction bits, clip to sample range
  function automatic sample_t filter_model();
    longint acc;
    sample_t result;
    acc = 0;
    for (int k = 0; k < NUM_TAPS; k++) begin
      acc += longint'(coef_model[k]) * longint'(hist[k]);
    end
    acc = (acc + (longint'(1) << (COEF_FRAC - 1))) >>> COEF_FRAC;
    if (acc > longint'(SAMPLE_MAX)) begin
      result = SAMPLE_MAX;
    end else if (acc < longint'(SAMPLE_MIN)) begin
      result = SAMPLE_MIN;
    end else begin
      result = sample_t'(acc);
    end
    return result;
  endfunction

  task automatic accept_beat(input sample_t x, input logic last);
    for (int k = NUM_TAPS - 1; k > 0; k--) begin
      hist[k] = hist[k-1];
    end
    hist[0] = x;
    exp_data.push_back(filter_model());
    exp_last.push_back(last);
  endtask

  ////////////////////////////////////////
  // Bus and stream drivers
  ////////////////////////////////////////

  task automatic write_setting(input set_addr_t addr, input set_data_t data);
    @(negedge clk);
    set_stb  = 1'b1;
    set_addr = addr;
    set_data = data;
    @(negedge clk);
    set_stb  = 1'b0;
  endtask

  task automatic read_back(input int sel, output rb_data_t value);
    write_setting(SR_READBACK, set_data_t'(sel));
    #1;
    value = rb_data;
  endtask

  // Seven reloads then the last write
  task automatic load_bank();
    for (int k = 0; k < NUM_TAPS - 1; k++) begin
      write_setting(SR_RELOAD, set_data_t'(load_vals[k]));
    end
    write_setting(SR_RELOAD_LAST, set_data_t'(load_vals[NUM_TAPS-1]));
  endtask

  task automatic commit_bank();
    write_setting(SR_CONFIG, '0);
    coef_model = load_vals;
  endtask

  // Sends all queued beats and drains the output queue
  task automatic run_stream(input int valid_pct, input int ready_pct);
    int   idle;
    logic presenting;
    idle       = 0;
    presenting = 1'b0;
    while ((stim_data.size() > 0 || exp_data.size() > 0) && !timed_out) begin
      @(negedge clk);
      if (!presenting && stim_data.size() > 0) begin
        presenting = ($urandom % 100) < valid_pct;
      end
      in_tvalid  = presenting;
      in_tdata   = presenting ? stim_data[0] : '0;
      in_tlast   = presenting ? stim_last[0] : 1'b0;
      out_tready = ($urandom % 100) < ready_pct;
      #1;
      idle++;
      if (out_tvalid && out_tready) begin
        idle = 0;
        if (exp_data.size() == 0) begin
          errors++;
          $display("Error at %0d ns: output beat arrived with nothing expected", $time);
        end else begin
          compare_sample("o_tdata", exp_data[0], out_tdata);
          compare_last("o_tlast", exp_last[0], out_tlast);
          last_out = out_tdata;
          void'(exp_data.pop_front());
          void'(exp_last.pop_front());
        end
      end
      if (presenting && in_tready) begin
        idle = 0;
        accept_beat(stim_data[0], stim_last[0]);
        void'(stim_data.pop_front());
        void'(stim_last.pop_front());
        presenting = 1'b0;
      end
      if (idle > WAIT_LIMIT) begin
        timed_out = 1'b1;
        errors++;
        $display("Timeout at %0d ns: stream stalled, %0d outputs still expected",
                 $time, exp_data.size());
      end
    end
    @(negedge clk);
    in_tvalid  = 1'b0;
    in_tlast   = 1'b0;
    out_tready = 1'b1;
    #1;
    // Nothing left in flight, so no repeated beat
    if (!timed_out) begin
      compare_flag("o_tvalid", 1'b0, out_tvalid);
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    if (errors == errors_before) begin
      tests_passed++;
      $display("Test %s: passed", name);
    end else begin
      tests_failed++;
      $display("Test %s: failed with %0d errors", name, errors - errors_before);
    end
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  task automatic after_reset();
    int       start;
    rb_data_t rb;
    start = errors;
    @(negedge clk);
    #1;
    compare_flag("o_tvalid", 1'b0, out_tvalid);
    compare_flag("o_tready_in", 1'b1, in_tready);
    read_back(0, rb);
    compare_rb("o_rb_data", rb_data_t'(NUM_TAPS), rb);
    read_back(1, rb);
    compare_rb("o_rb_data", '0, rb);
    read_back(5, rb);
    compare_rb("o_rb_data", RB_INVALID, rb);
    report_test("after_reset", start);
  endtask

  task automatic impulse_response();
    int       start;
    rb_data_t rb;
    start = errors;
    load_vals = '{16'sd1000, -16'sd2000, 16'sd4096, 16'sd16384,
                  -16'sd32768, 16'sd32767, 16'sd7, -16'sd1};
    load_bank();
    // Complete flag in bit 8, index back at 0
    read_back(1, rb);
    compare_rb("o_rb_data", rb_data_t'(9'h100), rb);
    commit_bank();
    for (int n = 0; n < NUM_TAPS; n++) begin
      stim_data.push_back(n == 0 ? SAMPLE_MAX : sample_t'(0));
      stim_last.push_back(n == NUM_TAPS - 1);
    end
    run_stream(100, 100);
    report_test("impulse_response", start);
  endtask

  task automatic random_backpressure();
    int start;
    int remaining;
    start     = errors;
    remaining = 0;
    for (int n = 0; n < 60; n++) begin
      if (remaining == 0) begin
        remaining = 1 + int'($urandom % 8);
      end
      remaining--;
      stim_data.push_back(sample_t'($urandom));
      stim_last.push_back(remaining == 0 || n == 59);
    end
    run_stream(80, 60);
    report_test("random_backpressure", start);
  endtask

  task automatic saturation_limits();
    int start;
    start = errors;
    for (int k = 0; k < NUM_TAPS; k++) begin
      load_vals[k] = 16'sd32767;
    end
    load_bank();
    commit_bank();
    for (int n = 0; n < 10; n++) begin
      stim_data.push_back(SAMPLE_MAX);
      stim_last.push_back(n == 9);
    end
    run_stream(90, 70);
    compare_sample("o_tdata", SAMPLE_MAX, last_out);
    for (int n = 0; n < 10; n++) begin
      stim_data.push_back(SAMPLE_MIN);
      stim_last.push_back(n == 9);
    end
    run_stream(90, 70);
    compare_sample("o_tdata", SAMPLE_MIN, last_out);
    report_test("saturation_limits", start);
  endtask

  task automatic partial_reload();
    int       start;
    rb_data_t rb;
    start = errors;
    // Three reloads and no last write, so the commit is dropped
    for (int k = 0; k < 3; k++) begin
      write_setting(SR_RELOAD, 32'd5);
    end
    write_setting(SR_CONFIG, '0);
    read_back(1, rb);
    compare_rb("o_rb_data", rb_data_t'(3), rb);
    for (int n = 0; n < 12; n++) begin
      stim_data.push_back(sample_t'(int'($urandom % 4001) - 2000));
      stim_last.push_back(n == 11);
    end
    run_stream(70, 60);
    report_test("partial_reload", start);
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    void'($urandom(32'hc8166c3e));
    reset        = 1'b1;
    set_stb      = 1'b0;
    set_addr     = '0;
    set_data     = '0;
    in_tdata     = '0;
    in_tlast     = 1'b0;
    in_tvalid    = 1'b0;
    out_tready   = 1'b1;
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    timed_out    = 1'b0;
    last_out     = '0;
    for (int k = 0; k < NUM_TAPS; k++) begin
      coef_model[k] = '0;
      load_vals[k]  = '0;
      hist[k]       = '0;
    end
    repeat (8) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    after_reset();
    if (!timed_out) impulse_response();
    if (!timed_out) random_backpressure();
    if (!timed_out) saturation_limits();
    if (!timed_out) partial_reload();

    $display("Tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
    if (errors == 0 && tests_failed == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule
